// File: files.f
+incdir+verilog
verilog/exePkg.sv
verilog/exeIf.sv
verilog/issueStage.sv
verilog/forwardUnit.sv
verilog/exeUnit.sv
verilog/retireStage.sv
verilog/execTop.sv
sim/clkGen.sv
sim/execChecker.sv
sim/exec_assert.sv
sim/execTb.sv

// File: sim/clkGen.sv
`timescale 1ns/10ps

module clkGen #(
	parameter int periodNs = 8,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic arstN
);
	// Free-running clock
	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// Reset held for a few edges, released just after one
	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1;
		arstN = 1'b1;
	end
endmodule

// File: sim/execChecker.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module execChecker (
	input  logic clk,
	input  logic arstN,
	input  logic issueValid,
	input  logic [3:0] aluOp,
	input  logic [1:0] bSrc,
	input  logic [1:0] pcMode,
	input  logic [`EXE_RIW-1:0] rs,
	input  logic [`EXE_RIW-1:0] rt,
	input  logic [`EXE_RIW-1:0] rd,
	input  logic regWrite,
	input  logic [`EXE_DW-1:0] imm,
	input  logic [`EXE_DW-1:0] pc,
	input  logic resValid,
	input  logic [`EXE_DW-1:0] resData,
	input  logic [`EXE_RIW-1:0] resDest,
	input  logic resWrite,
	input  logic [`EXE_DW-1:0] newPc,
	input  logic [`EXE_DW-1:0] storeData,
	output int doneCount,
	output int errCount
);
	// Sequential register file model
	logic [`EXE_DW-1:0] model [`EXE_NREG];
	// Expected results in issue order
	logic [`EXE_DW-1:0] dataQ [$];
	logic [`EXE_DW-1:0] pcQ [$];
	logic [`EXE_DW-1:0] storeQ [$];
	// Write flag on top of the destination
	logic [`EXE_RIW:0] destQ [$];
	int dueQ [$];
	int edgeCount;
	int testBad;

	initial
	begin
		for (int i = 0; i < `EXE_NREG; i++)
			model[i] = '0;
		edgeCount = 0;
		doneCount = 0;
		errCount = 0;
	end

	// ALU behavior, undefined codes give zero
	function automatic logic [`EXE_DW-1:0] aluModel(
		input logic [3:0] op,
		input logic [`EXE_DW-1:0] a,
		input logic [`EXE_DW-1:0] b
	);
		aluModel = '0;
		case (op)
			4'd0: aluModel = a + b;
			4'd1: aluModel = a - b;
			4'd2: aluModel = a & b;
			4'd3: aluModel = a | b;
			4'd4: aluModel = a ^ b;
			4'd5: aluModel = ~a;
			4'd6: if (b < 16) aluModel = a << b[3:0];
			4'd7: if (b < 16) aluModel = a >> b[3:0];
			// Past 15 only sign bits are left
			4'd8:
			begin
				if (b < 16)
					aluModel = $signed(a) >>> b[3:0];
				else
					aluModel = {`EXE_DW{a[`EXE_DW-1]}};
			end
			default: aluModel = '0;
		endcase
	endfunction

	task automatic compareField(
		input string name,
		input logic [`EXE_DW-1:0] expVal,
		input logic [`EXE_DW-1:0] gotVal
	);
		if (gotVal !== expVal)
		begin
			$display("ERROR test %0d %s expected %h got %h", doneCount + 1, name, expVal, gotVal);
			testBad = testBad + 1;
		end
	endtask

	////////////////////////////////////////
	// Issue side, model runs in program order
	////////////////////////////////////////

	always @(posedge clk)
	begin : issueModel
		logic [`EXE_DW-1:0] a;
		logic [`EXE_DW-1:0] b;
		logic [`EXE_DW-1:0] rtVal;
		logic [`EXE_DW-1:0] res;
		logic [31:0] wide;
		logic [`EXE_DW-1:0] target;
		edgeCount = edgeCount + 1;
		if (arstN && issueValid)
		begin
			// r0 reads zero
			a = (rs == 0) ? '0 : model[rs];
			rtVal = (rt == 0) ? '0 : model[rt];
			if (bSrc == 2'd0)
				b = rtVal;
			else if (bSrc == 2'd1)
				b = imm;
			else
				b = '0;
			res = aluModel(aluOp, a, b);
			// Word offset, wraps at 16 bits
			wide = pc + imm * 4;
			target = wide[`EXE_DW-1:0];
			case (pcMode)
				2'd0: pcQ.push_back(target);
				2'd1: pcQ.push_back(a);
				2'd2: pcQ.push_back((a == 0) ? target : pc);
				default: pcQ.push_back((a != 0) ? target : pc);
			endcase
			dataQ.push_back(res);
			storeQ.push_back(rtVal);
			destQ.push_back({regWrite, rd});
			// Shows up after the next edge
			dueQ.push_back(edgeCount + 1);
			if (regWrite && (rd != 0))
				model[rd] = res;
		end
	end

	////////////////////////////////////////
	// Result side, sampled mid-cycle
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if ((dueQ.size() > 0) && (dueQ[0] == edgeCount))
		begin
			testBad = 0;
			if (resValid !== 1'b1)
			begin
				$display("Test %0d gave no result two edges after it was issued", doneCount + 1);
				testBad = 1;
			end
			else
			begin
				compareField("resData", dataQ[0], resData);
				compareField("resDest", destQ[0][`EXE_RIW-1:0], resDest);
				compareField("resWrite", destQ[0][`EXE_RIW], resWrite);
				compareField("newPc", pcQ[0], newPc);
				compareField("storeData", storeQ[0], storeData);
				if (testBad == 0)
					$display("ok    test %0d resData=%h newPc=%h storeData=%h",
						doneCount + 1, resData, newPc, storeData);
			end
			errCount = errCount + testBad;
			doneCount = doneCount + 1;
			void'(dueQ.pop_front());
			void'(dataQ.pop_front());
			void'(pcQ.pop_front());
			void'(storeQ.pop_front());
			void'(destQ.pop_front());
		end
		else if (resValid === 1'b1)
		begin
			$display("A result came out with no issued instruction waiting for it");
			errCount = errCount + 1;
		end
	end
endmodule

// File: sim/execTb.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module execTb;
	logic clk;
	logic arstN;
	logic issueValid;
	exePkg::aluOpE aluOp;
	exePkg::bSrcE bSrc;
	exePkg::pcModeE pcMode;
	logic [`EXE_RIW-1:0] rs;
	logic [`EXE_RIW-1:0] rt;
	logic [`EXE_RIW-1:0] rd;
	logic regWrite;
	logic [`EXE_DW-1:0] imm;
	logic [`EXE_DW-1:0] pc;
	logic resValid;
	logic [`EXE_DW-1:0] resData;
	logic [`EXE_RIW-1:0] resDest;
	logic resWrite;
	logic [`EXE_DW-1:0] newPc;
	logic [`EXE_DW-1:0] storeData;
	int doneCount;
	int errCount;
	// Nine fields per pattern row
	logic [`EXE_DW-1:0] patField [0:575];
	int patCount;
	logic loaded;
	logic [31:0] lcgState;

	clkGen clocks (.clk(clk), .arstN(arstN));

	execTop UUT (.clk(clk), .arstN(arstN), .issueValid(issueValid), .aluOp(aluOp),
		.bSrc(bSrc), .pcMode(pcMode), .rs(rs), .rt(rt), .rd(rd), .regWrite(regWrite),
		.imm(imm), .pc(pc), .resValid(resValid), .resData(resData), .resDest(resDest),
		.resWrite(resWrite), .newPc(newPc), .storeData(storeData));

	execChecker uCheck (.clk(clk), .arstN(arstN), .issueValid(issueValid), .aluOp(aluOp),
		.bSrc(bSrc), .pcMode(pcMode), .rs(rs), .rt(rt), .rd(rd), .regWrite(regWrite),
		.imm(imm), .pc(pc), .resValid(resValid), .resData(resData), .resDest(resDest),
		.resWrite(resWrite), .newPc(newPc), .storeData(storeData), .doneCount(doneCount),
		.errCount(errCount));

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		nextRandom = state * 32'd1103515245 + 32'd12345;
	endfunction

	// Comment lines fail the scan and drop out
	task automatic loadPatterns();
		int fd;
		int n;
		int b;
		string line;
		patCount = 0;
		fd = $fopen("sim/exec_patterns.txt", "r");
		if (fd == 0)
			$display("Pattern file sim/exec_patterns.txt could not be opened");
		else
		begin
			while (!$feof(fd) && (patCount < 64))
			begin
				if ($fgets(line, fd))
				begin
					b = patCount * 9;
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", patField[b],
						patField[b + 1], patField[b + 2], patField[b + 3], patField[b + 4],
						patField[b + 5], patField[b + 6], patField[b + 7], patField[b + 8]);
					if (n == 9)
						patCount = patCount + 1;
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////
	// Drive 1 ns after the rising edge
	////////////////////////////////////////

	task automatic issueOne(input int row);
		int b;
		b = row * 9;
		@(posedge clk);
		#1;
		issueValid = 1'b1;
		aluOp = exePkg::aluOpE'(patField[b][3:0]);
		bSrc = exePkg::bSrcE'(patField[b + 1][1:0]);
		pcMode = exePkg::pcModeE'(patField[b + 2][1:0]);
		rs = patField[b + 3][`EXE_RIW-1:0];
		rt = patField[b + 4][`EXE_RIW-1:0];
		rd = patField[b + 5][`EXE_RIW-1:0];
		regWrite = patField[b + 6][0];
		imm = patField[b + 7];
		pc = patField[b + 8];
	endtask

	task automatic driveIdle();
		@(posedge clk);
		#1;
		issueValid = 1'b0;
	endtask

	initial
	begin
		int idle;
		issueValid = 1'b0;
		aluOp = exePkg::ADD;
		bSrc = exePkg::RT;
		pcMode = exePkg::BR;
		rs = '0;
		rt = '0;
		rd = '0;
		regWrite = 1'b0;
		imm = '0;
		pc = '0;
		lcgState = 32'h4855;
		loaded = 1'b0;
		loadPatterns();
		loaded = 1'b1;
		wait (arstN === 1'b1);
		// Random gaps of 0 to 2 idle cycles
		for (int i = 0; i < patCount; i++)
		begin
			issueOne(i);
			lcgState = nextRandom(lcgState);
			idle = (lcgState >> 16) % 3;
			repeat (idle) driveIdle();
		end
		driveIdle();
		wait (doneCount == patCount);
		// Catch stray results
		repeat (4) @(posedge clk);
		$display("Done: %0d of %0d tests checked, %0d errors, %0d assertion failures",
			doneCount, patCount, errCount, UUT.uAssert.failCount);
		if ((errCount == 0) && (UUT.uAssert.failCount == 0) && (doneCount == patCount)
			&& (patCount > 0))
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the pattern count
	initial
	begin
		wait ((loaded === 1'b1) && (arstN === 1'b1));
		repeat (patCount * 4 + 20) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", patCount * 4 + 20);
		$display("Simulation failed");
		$finish;
	end
endmodule

// File: sim/exec_assert.sv
`timescale 1ns/10ps

module execAssert (
	input logic clk,
	input logic arstN,
	input logic issueValid,
	input logic resValid
);
	// Failed assertion count, read by the testbench top
	int failCount = 0;

	// Issue shows up as a result two edges on
	property issueReaches;
		@(posedge clk) disable iff (!arstN)
		issueValid |-> ##2 resValid;
	endproperty

	// Idle slots stay idle
	property idleStaysIdle;
		@(posedge clk) disable iff (!arstN)
		!issueValid |-> ##2 !resValid;
	endproperty

	// Pipeline empty right after reset
	property cleanAfterReset;
		@(posedge clk) $rose(arstN) |-> !resValid;
	endproperty

	validFollows: assert property (issueReaches)
		else
		begin
			$error("resValid missing two edges after issueValid");
			failCount = failCount + 1;
		end
	idleFollows: assert property (idleStaysIdle)
		else
		begin
			$error("resValid high without an issue two edges before");
			failCount = failCount + 1;
		end
	resetClear: assert property (cleanAfterReset)
		else
		begin
			$error("resValid high in the first cycle after reset");
			failCount = failCount + 1;
		end
endmodule

bind execTop execAssert uAssert (.clk(clk), .arstN(arstN), .issueValid(issueValid),
	.resValid(resValid));

// File: sim/exec_patterns.txt
// Columns in hex: aluOp bSrc pcMode rs rt rd regWrite imm pc
// bSrc 0 rt, 1 imm, 2 and 3 zero; pcMode 0 BR, 1 JR, 2 BEQZ, 3 BNEZ
0 1 0 0 0 1 1 1234 0100
0 1 0 1 0 2 1 00f0 0104
1 0 1 2 1 3 1 0000 0108
2 0 2 3 2 4 1 0000 010c
3 0 3 1 3 5 1 0010 0110
4 0 0 4 5 6 1 0000 0114
5 2 0 6 0 7 1 0000 0118
0 0 2 0 7 0 1 3fff ffe0
0 0 3 0 0 1 1 0004 0120
9 0 0 2 3 2 1 0000 0124
f 1 1 4 0 2 1 00ff 0128
0 1 0 0 0 5 1 8421 012c
0 1 0 0 0 6 1 0013 0130
6 1 0 5 0 4 1 0004 0134
6 1 0 5 0 4 1 0010 0138
7 0 0 5 6 3 1 0000 013c
7 1 0 5 0 3 1 0003 0140
8 1 0 5 0 7 1 0003 0144
8 0 0 5 6 7 1 0000 0148
0 3 1 5 5 1 1 0000 014c
0 1 0 5 0 3 0 1111 0150
1 0 2 3 7 2 1 c001 fff0
2 1 0 1 0 6 1 0ff0 0154
4 2 0 1 1 6 1 0000 0158
1 1 3 6 0 6 1 0001 015c

// File: verilog/exeIf.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

// One issued instruction, as held in the ID/EX register
interface exeIf;
	logic valid;
	exePkg::aluOpE aluOp;
	exePkg::bSrcE bSrc;
	exePkg::pcModeE pcMode;
	// Register indices and write flag
	logic [`EXE_RIW-1:0] rs;
	logic [`EXE_RIW-1:0] rt;
	logic [`EXE_RIW-1:0] rd;
	logic regWrite;
	// Operand values read at issue
	logic [`EXE_DW-1:0] rsData;
	logic [`EXE_DW-1:0] rtData;
	logic [`EXE_DW-1:0] imm;
	logic [`EXE_DW-1:0] pc;

	// Issue stage owns the ID/EX register
	modport issue (output valid, aluOp, bSrc, pcMode, rs, rt, rd, regWrite,
		rsData, rtData, imm, pc);

	// Execute reads the whole instruction
	modport exe (input valid, aluOp, bSrc, pcMode, rs, rt, rd, regWrite,
		rsData, rtData, imm, pc);

	// Hazard compare needs sources only
	modport fwd (input valid, rs, rt);
endinterface

// File: verilog/exePkg.sv
package exePkg;

	// ALU function, codes 9 to 15 give zero
	typedef enum logic [3:0]
	{
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		NOT = 4'd5,
		SLL = 4'd6,
		SRL = 4'd7,
		SRA = 4'd8
	} aluOpE;

	// Operand B source, code 3 also gives zero
	typedef enum logic [1:0]
	{
		RT   = 2'd0,
		IMM  = 2'd1,
		ZERO = 2'd2
	} bSrcE;

	// Next-PC mode
	typedef enum logic [1:0]
	{
		BR   = 2'd0,
		JR   = 2'd1,
		BEQZ = 2'd2,
		BNEZ = 2'd3
	} pcModeE;

	// Operand source picked by the forwarding unit
	typedef enum logic [1:0]
	{
		REG   = 2'd0,
		EXMEM = 2'd1,
		MEMWB = 2'd2
	} fwdSelE;

endpackage

// File: verilog/exeUnit.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module exeUnit (
	exeIf.exe iss,
	input  exePkg::fwdSelE fwdA,
	input  exePkg::fwdSelE fwdB,
	input  logic [`EXE_DW-1:0] exMemRes,
	input  logic [`EXE_DW-1:0] memWbRes,
	output logic [`EXE_DW-1:0] aluRes,
	output logic [`EXE_DW-1:0] newPc,
	output logic [`EXE_DW-1:0] storeData
);
	logic [`EXE_DW-1:0] opA;
	logic [`EXE_DW-1:0] rtFwd;
	logic [`EXE_DW-1:0] opB;
	logic [`EXE_DW-1:0] shiftImm;
	logic [`EXE_DW-1:0] brTarget;

	// Bypass mux shared by both operands
	function automatic logic [`EXE_DW-1:0] bypass(
		input exePkg::fwdSelE sel,
		input logic [`EXE_DW-1:0] regVal,
		input logic [`EXE_DW-1:0] emVal,
		input logic [`EXE_DW-1:0] mwVal
	);
		case (sel)
			exePkg::EXMEM: bypass = emVal;
			exePkg::MEMWB: bypass = mwVal;
			default:       bypass = regVal;
		endcase
	endfunction

	////////////////////////////////////////
	// Operands
	////////////////////////////////////////

	assign opA = bypass(fwdA, iss.rsData, exMemRes, memWbRes);
	assign rtFwd = bypass(fwdB, iss.rtData, exMemRes, memWbRes);

	// Store data is rt after forwarding, never the immediate
	assign storeData = rtFwd;

	// Operand B select
	always_comb
	begin
		case (iss.bSrc)
			exePkg::RT:  opB = rtFwd;
			exePkg::IMM: opB = iss.imm;
			default:     opB = '0;
		endcase
	end

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	// Shift amount is all of B, 16 and up flushes
	always_comb
	begin
		case (iss.aluOp)
			exePkg::ADD: aluRes = opA + opB;
			exePkg::SUB: aluRes = opA - opB;
			exePkg::AND: aluRes = opA & opB;
			exePkg::OR:  aluRes = opA | opB;
			exePkg::XOR: aluRes = opA ^ opB;
			exePkg::NOT: aluRes = ~opA;
			exePkg::SLL: aluRes = opA << opB;
			exePkg::SRL: aluRes = opA >> opB;
			// Sign fill
			exePkg::SRA: aluRes = $signed(opA) >>> opB;
			default:     aluRes = '0;
		endcase
	end

	////////////////////////////////////////
	// Branch target and next PC
	////////////////////////////////////////

	// Word offset, top two imm bits drop out
	assign shiftImm = {iss.imm[`EXE_DW-3:0], 2'b00};
	assign brTarget = iss.pc + shiftImm;

	always_comb
	begin
		case (iss.pcMode)
			exePkg::BR:   newPc = brTarget;
			exePkg::JR:   newPc = opA;
			exePkg::BEQZ: newPc = (opA == '0) ? brTarget : iss.pc;
			// BNEZ
			default:      newPc = (opA != '0) ? brTarget : iss.pc;
		endcase
	end
endmodule

// File: verilog/exe_consts.svh
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Data and PC width
`define EXE_DW 16

// Architectural registers, r0 hardwired to zero
`define EXE_NREG 8

// Register index width
`define EXE_RIW 3

`endif

// File: verilog/execTop.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module execTop (
	input  logic clk,
	input  logic arstN,
	input  logic issueValid,
	input  exePkg::aluOpE aluOp,
	input  exePkg::bSrcE bSrc,
	input  exePkg::pcModeE pcMode,
	input  logic [`EXE_RIW-1:0] rs,
	input  logic [`EXE_RIW-1:0] rt,
	input  logic [`EXE_RIW-1:0] rd,
	input  logic regWrite,
	input  logic [`EXE_DW-1:0] imm,
	input  logic [`EXE_DW-1:0] pc,
	output logic resValid,
	output logic [`EXE_DW-1:0] resData,
	output logic [`EXE_RIW-1:0] resDest,
	output logic resWrite,
	output logic [`EXE_DW-1:0] newPc,
	output logic [`EXE_DW-1:0] storeData
);
	exePkg::fwdSelE fwdA;
	exePkg::fwdSelE fwdB;
	// Execute results into EX/MEM
	logic [`EXE_DW-1:0] exeRes;
	logic [`EXE_DW-1:0] exeNewPc;
	logic [`EXE_DW-1:0] exeStore;
	// Older stages seen by forwarding
	logic [`EXE_RIW-1:0] exMemRd;
	logic exMemWrite;
	logic [`EXE_RIW-1:0] memWbRd;
	logic memWbWrite;
	logic [`EXE_DW-1:0] memWbRes;
	// Writeback port
	logic wbEn;
	logic [`EXE_RIW-1:0] wbIdx;
	logic [`EXE_DW-1:0] wbData;

	// ID/EX contents
	exeIf issIf ();

	issueStage uIssue (.clk(clk), .arstN(arstN), .issueValid(issueValid), .aluOp(aluOp),
		.bSrc(bSrc), .pcMode(pcMode), .rs(rs), .rt(rt), .rd(rd), .regWrite(regWrite),
		.imm(imm), .pc(pc), .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData), .iss(issIf.issue));

	forwardUnit uFwd (.iss(issIf.fwd), .exMemWrite(exMemWrite), .exMemRd(exMemRd),
		.memWbWrite(memWbWrite), .memWbRd(memWbRd), .fwdA(fwdA), .fwdB(fwdB));

	exeUnit uExe (.iss(issIf.exe), .fwdA(fwdA), .fwdB(fwdB), .exMemRes(resData),
		.memWbRes(memWbRes), .aluRes(exeRes), .newPc(exeNewPc), .storeData(exeStore));

	// EX/MEM result doubles as the top-level output
	retireStage uRetire (.clk(clk), .arstN(arstN), .valid(issIf.valid), .rd(issIf.rd),
		.regWrite(issIf.regWrite), .aluRes(exeRes), .newPc(exeNewPc), .storeData(exeStore),
		.resValid(resValid), .resData(resData), .resDest(resDest), .resWrite(resWrite),
		.resNewPc(newPc), .resStore(storeData), .exMemRd(exMemRd), .exMemWrite(exMemWrite),
		.memWbRd(memWbRd), .memWbWrite(memWbWrite), .memWbRes(memWbRes), .wbEn(wbEn),
		.wbIdx(wbIdx), .wbData(wbData));
endmodule

// File: verilog/forwardUnit.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module forwardUnit (
	exeIf.fwd iss,
	input  logic exMemWrite,
	input  logic [`EXE_RIW-1:0] exMemRd,
	input  logic memWbWrite,
	input  logic [`EXE_RIW-1:0] memWbRd,
	output exePkg::fwdSelE fwdA,
	output exePkg::fwdSelE fwdB
);
	// Youngest matching producer wins
	function automatic exePkg::fwdSelE pickSrc(
		input logic live,
		input logic [`EXE_RIW-1:0] src,
		input logic emWrite,
		input logic [`EXE_RIW-1:0] emRd,
		input logic mwWrite,
		input logic [`EXE_RIW-1:0] mwRd
	);
		// r0 and idle slots keep the register value
		if (!live || (src == '0))
			pickSrc = exePkg::REG;
		else if (emWrite && (emRd == src))
			pickSrc = exePkg::EXMEM;
		else if (mwWrite && (mwRd == src))
			pickSrc = exePkg::MEMWB;
		else
			pickSrc = exePkg::REG;
	endfunction

	// Operand A from rs
	assign fwdA = pickSrc(iss.valid, iss.rs, exMemWrite, exMemRd, memWbWrite, memWbRd);

	// rt value, used for operand B and store data
	assign fwdB = pickSrc(iss.valid, iss.rt, exMemWrite, exMemRd, memWbWrite, memWbRd);
endmodule

// File: verilog/issueStage.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module issueStage (
	input  logic clk,
	input  logic arstN,
	input  logic issueValid,
	input  exePkg::aluOpE aluOp,
	input  exePkg::bSrcE bSrc,
	input  exePkg::pcModeE pcMode,
	input  logic [`EXE_RIW-1:0] rs,
	input  logic [`EXE_RIW-1:0] rt,
	input  logic [`EXE_RIW-1:0] rd,
	input  logic regWrite,
	input  logic [`EXE_DW-1:0] imm,
	input  logic [`EXE_DW-1:0] pc,
	input  logic wbEn,
	input  logic [`EXE_RIW-1:0] wbIdx,
	input  logic [`EXE_DW-1:0] wbData,
	exeIf.issue iss
);
	logic [`EXE_DW-1:0] regFile [`EXE_NREG];
	logic [`EXE_DW-1:0] rsRead;
	logic [`EXE_DW-1:0] rtRead;

	// Read port, r0 forced to zero, same-cycle writeback bypassed
	function automatic logic [`EXE_DW-1:0] readPort(
		input logic [`EXE_RIW-1:0] idx,
		input logic [`EXE_DW-1:0] stored,
		input logic we,
		input logic [`EXE_RIW-1:0] wIdx,
		input logic [`EXE_DW-1:0] wData
	);
		if (idx == '0)
			readPort = '0;
		else if (we && (wIdx == idx))
			readPort = wData;
		else
			readPort = stored;
	endfunction

	assign rsRead = readPort(rs, regFile[rs], wbEn, wbIdx, wbData);
	assign rtRead = readPort(rt, regFile[rt], wbEn, wbIdx, wbData);

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////

	// Cleared on reset, r0 never written
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `EXE_NREG; i++)
				regFile[i] <= '0;
		end
		else if (wbEn && (wbIdx != '0))
			regFile[wbIdx] <= wbData;
	end

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			iss.valid <= 1'b0;
		else
			iss.valid <= issueValid;
	end

	// Payload loads every cycle, qualified by valid downstream
	always_ff @(posedge clk)
	begin
		iss.aluOp <= aluOp;
		iss.bSrc <= bSrc;
		iss.pcMode <= pcMode;
		iss.rs <= rs;
		iss.rt <= rt;
		iss.rd <= rd;
		iss.regWrite <= regWrite;
		iss.rsData <= rsRead;
		iss.rtData <= rtRead;
		iss.imm <= imm;
		iss.pc <= pc;
	end
endmodule

// File: verilog/retireStage.sv
`timescale 1ns/10ps
`include "exe_consts.svh"

module retireStage (
	input  logic clk,
	input  logic arstN,
	input  logic valid,
	input  logic [`EXE_RIW-1:0] rd,
	input  logic regWrite,
	input  logic [`EXE_DW-1:0] aluRes,
	input  logic [`EXE_DW-1:0] newPc,
	input  logic [`EXE_DW-1:0] storeData,
	output logic resValid,
	output logic [`EXE_DW-1:0] resData,
	output logic [`EXE_RIW-1:0] resDest,
	output logic resWrite,
	output logic [`EXE_DW-1:0] resNewPc,
	output logic [`EXE_DW-1:0] resStore,
	output logic [`EXE_RIW-1:0] exMemRd,
	output logic exMemWrite,
	output logic [`EXE_RIW-1:0] memWbRd,
	output logic memWbWrite,
	output logic [`EXE_DW-1:0] memWbRes,
	output logic wbEn,
	output logic [`EXE_RIW-1:0] wbIdx,
	output logic [`EXE_DW-1:0] wbData
);
	////////////////////////////////////////
	// EX/MEM and MEM/WB control
	////////////////////////////////////////

	// Write flags only live with a valid instruction
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			resValid <= 1'b0;
			resWrite <= 1'b0;
			memWbWrite <= 1'b0;
		end
		else
		begin
			resValid <= valid;
			resWrite <= valid && regWrite;
			memWbWrite <= resValid && resWrite;
		end
	end

	// Payload, no reset
	always_ff @(posedge clk)
	begin
		resData <= aluRes;
		resDest <= rd;
		resNewPc <= newPc;
		resStore <= storeData;
		memWbRd <= resDest;
		memWbRes <= resData;
	end

	// EX/MEM view for the hazard compare
	assign exMemRd = resDest;
	assign exMemWrite = resWrite;

	// MEM/WB drives the register file write port
	assign wbEn = memWbWrite;
	assign wbIdx = memWbRd;
	assign wbData = memWbRes;
endmodule
